// ==== design/download_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module download_decoder (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  wire                      dl_active_i,
    input  wire [`LDR_IDX_W-1:0]     dl_index_i,
    output loader_pkg::dl_kind_t     kind_o,
    output logic                     start_o,
    output logic                     end_o
);

    loader_pkg::dl_kind_t kind_q;

    // ====================
    // Index decode
    // ====================
    always_comb begin
        kind_o = loader_pkg::DL_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                `LDR_IDX_ROM:   kind_o = loader_pkg::DL_ROM;
                `LDR_IDX_PRG_A,
                `LDR_IDX_PRG_B: kind_o = loader_pkg::DL_PRG;
                `LDR_IDX_TAP:   kind_o = loader_pkg::DL_TAP;
                default:        kind_o = loader_pkg::DL_NONE;
            endcase
        end
    end

    // ====================
    // Edge detection
    // ====================
    // A change of kind ends the old download and starts the new one
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            kind_q  <= loader_pkg::DL_NONE;
            start_o <= 1'b0;
            end_o   <= 1'b0;
        end else begin
            kind_q  <= kind_o;
            start_o <= (kind_o != loader_pkg::DL_NONE) && (kind_o != kind_q);
            end_o   <= (kind_q != loader_pkg::DL_NONE) && (kind_o != kind_q);
        end
    end

endmodule

`default_nettype wire

// ==== design/load_settings.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module load_settings (
    input  wire                  clk_sys,
    input  wire                  reset,
    input  wire                  cfg_wr_i,
    input  wire [`LDR_CFG_W-1:0] cfg_word_i,
    output logic                 no_header_o
);

    // ====================
    // Settings word
    // ====================
    logic [`LDR_CFG_W-1:0] cfg_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (cfg_wr_i) begin
            cfg_q <= cfg_word_i;
        end
    end

    // ====================
    // Decoded options
    // ====================
    // Set means the PRG has no two-byte load address
    assign no_header_o = cfg_q[`LDR_CFG_NO_HDR_BIT];

endmodule

`default_nettype wire

// ==== design/loader_cfg.svh ====
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ====================
// Bus widths
// ====================
`define LDR_ADDR_W          23
`define LDR_OFS_W           25
`define LDR_DATA_W          8
`define LDR_IDX_W           8
`define LDR_CFG_W           32

// ====================
// Download index codes
// ====================
`define LDR_IDX_ROM         8'h00
`define LDR_IDX_PRG_A       8'h01
`define LDR_IDX_PRG_B       8'h41
`define LDR_IDX_TAP         8'h81

// ====================
// Fixed addresses
// ====================
// Tape images live above the system ROMs
`define LDR_TAP_BASE        23'h20000
// Cartridge slot used by headerless PRG files
`define LDR_PRG_NOHDR_ADDR  16'hA000
// Last byte a PRG may touch before the ROM area
`define LDR_PRG_LIMIT       16'hBFFF

// Injection step that issues the reset request
`define LDR_INJ_LAST_STEP   5'd31
// Address bit that selects the NTSC kernal copy
`define LDR_NTSC_BANK_BIT   16
// Settings bit for files without a load address
`define LDR_CFG_NO_HDR_BIT  2

`endif

// ==== design/loader_pkg.sv ====
`default_nettype none

`include "loader_cfg.svh"

package loader_pkg;

    // Kind of the download in progress
    typedef enum logic [1:0] {
        DL_NONE,
        DL_ROM,
        DL_PRG,
        DL_TAP
    } dl_kind_t;

    // One byte of the incoming download stream
    typedef struct packed {
        logic                   strb;
        logic [`LDR_OFS_W-1:0]  ofs;
        logic [`LDR_DATA_W-1:0] data;
    } dl_beat_t;

    // Write request towards memory
    typedef struct packed {
        logic                   we;
        logic                   internal;
        logic [`LDR_ADDR_W-1:0] addr;
        logic [`LDR_DATA_W-1:0] data;
    } mem_req_t;

    // PRG body byte or pointer injection, 16-bit machine address
    typedef struct packed {
        logic                   we;
        logic                   inject;
        logic [15:0]            addr;
        logic [`LDR_DATA_W-1:0] data;
    } prg_wr_t;

endpackage

`default_nettype wire

// ==== design/loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module loader_top (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire                       dl_active_i,
    input  wire [`LDR_IDX_W-1:0]      dl_index_i,
    input  wire loader_pkg::dl_beat_t beat_i,
    input  wire                       cfg_wr_i,
    input  wire [`LDR_CFG_W-1:0]      cfg_word_i,
    output loader_pkg::mem_req_t      mem_req_o,
    output logic [`LDR_ADDR_W-1:0]    tap_end_o,
    output logic                      force_reset_o
);

    loader_pkg::dl_kind_t kind;
    loader_pkg::prg_wr_t  prg_wr;
    logic                 dl_end;
    logic                 no_header;

    load_settings u_settings (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .cfg_wr_i    (cfg_wr_i),
        .cfg_word_i  (cfg_word_i),
        .no_header_o (no_header)
    );

    // Start pulse is not needed by the loaders
    download_decoder u_decoder (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .dl_active_i (dl_active_i),
        .dl_index_i  (dl_index_i),
        .kind_o      (kind),
        .start_o     (),
        .end_o       (dl_end)
    );

    prg_loader u_prg (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .beat_i        (beat_i),
        .kind_i        (kind),
        .end_i         (dl_end),
        .no_header_i   (no_header),
        .prg_wr_o      (prg_wr),
        .force_reset_o (force_reset_o)
    );

    target_addr_map u_map (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .beat_i    (beat_i),
        .kind_i    (kind),
        .prg_wr_i  (prg_wr),
        .mem_req_o (mem_req_o),
        .tap_end_o (tap_end_o)
    );

endmodule

`default_nettype wire

// ==== design/prg_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module prg_loader (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  wire loader_pkg::dl_beat_t beat_i,
    input  wire loader_pkg::dl_kind_t kind_i,
    input  wire                     end_i,
    input  wire                     no_header_i,
    output loader_pkg::prg_wr_t     prg_wr_o,
    output logic                    force_reset_o
);

    localparam logic [`LDR_OFS_W-1:0] OFS_HDR_LO = 0;
    localparam logic [`LDR_OFS_W-1:0] OFS_HDR_HI = 1;
    localparam logic [`LDR_OFS_W-1:0] OFS_BODY   = 2;

    logic        prg_strb;
    logic [15:0] load_ptr;
    logic [15:0] ptr_nxt;
    logic        ptr_write;
    logic        in_prg;
    logic        auto_reset;
    logic [4:0]  inj_step;
    logic        inj_slot;
    logic [15:0] inj_addr;

    assign prg_strb = beat_i.strb && (kind_i == loader_pkg::DL_PRG);

    // ====================
    // Load pointer
    // ====================
    // The written address is the updated pointer
    always_comb begin
        ptr_nxt   = load_ptr;
        ptr_write = 1'b1;
        if (!no_header_i) begin
            if (beat_i.ofs == OFS_HDR_LO) begin
                ptr_nxt[7:0] = beat_i.data;
                ptr_write    = 1'b0;
            end else if (beat_i.ofs == OFS_HDR_HI) begin
                ptr_nxt[15:8] = beat_i.data;
                ptr_write     = 1'b0;
            end else if (beat_i.ofs != OFS_BODY && load_ptr != `LDR_PRG_LIMIT) begin
                ptr_nxt = load_ptr + 16'd1;
            end
        end else begin
            if (beat_i.ofs == OFS_HDR_LO) begin
                ptr_nxt = `LDR_PRG_NOHDR_ADDR;
            end else if (load_ptr != `LDR_PRG_LIMIT) begin
                ptr_nxt = load_ptr + 16'd1;
            end
        end
    end

    // ====================
    // Injection targets
    // ====================
    // Low byte on steps 1,5,9,13 and high byte on 3,7,11,15
    assign inj_slot = inj_step[0] && !inj_step[4];

    always_comb begin
        case (inj_step[3:1])
            3'd0:    inj_addr = 16'h002D;
            3'd1:    inj_addr = 16'h002E;
            3'd2:    inj_addr = 16'h002F;
            3'd3:    inj_addr = 16'h0030;
            3'd4:    inj_addr = 16'h0031;
            3'd5:    inj_addr = 16'h0032;
            3'd6:    inj_addr = 16'h00AE;
            default: inj_addr = 16'h00AF;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_wr_o.we     <= 1'b0;
            prg_wr_o.inject <= 1'b0;
            force_reset_o   <= 1'b0;
            in_prg          <= 1'b0;
            auto_reset      <= 1'b0;
            inj_step        <= 5'd0;
        end else begin
            prg_wr_o.we     <= 1'b0;
            prg_wr_o.inject <= 1'b0;
            force_reset_o   <= 1'b0;

            if (prg_strb) begin
                load_ptr      <= ptr_nxt;
                prg_wr_o.we   <= ptr_write;
                prg_wr_o.addr <= ptr_nxt;
                prg_wr_o.data <= beat_i.data;
                // Loaded into the cartridge slot so restart after loading
                if (ptr_write && ptr_nxt == `LDR_PRG_NOHDR_ADDR) begin
                    auto_reset <= 1'b1;
                end
            end

            if (end_i) begin
                in_prg <= 1'b0;
            end
            if (kind_i == loader_pkg::DL_PRG) begin
                in_prg <= 1'b1;
            end

            // Step counter wraps back to idle after step 31
            if (end_i && in_prg) begin
                inj_step <= 5'd1;
            end else if (inj_step != 5'd0) begin
                inj_step <= inj_step + 5'd1;
            end

            if (inj_slot) begin
                prg_wr_o.we     <= 1'b1;
                prg_wr_o.inject <= 1'b1;
                prg_wr_o.addr   <= inj_addr;
                prg_wr_o.data   <= inj_step[1] ? load_ptr[15:8] : load_ptr[7:0];
            end

            if (inj_step == `LDR_INJ_LAST_STEP) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/target_addr_map.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module target_addr_map (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire loader_pkg::dl_beat_t beat_i,
    input  wire loader_pkg::dl_kind_t kind_i,
    input  wire loader_pkg::prg_wr_t  prg_wr_i,
    output loader_pkg::mem_req_t      mem_req_o,
    output logic [`LDR_ADDR_W-1:0]    tap_end_o
);

    logic                   rom_strb;
    logic                   tap_strb;
    logic [`LDR_ADDR_W-1:0] rom_addr;
    logic                   rom_char;
    logic [`LDR_ADDR_W-1:0] tap_addr;
    logic                   prg_internal;

    assign rom_strb = beat_i.strb && (kind_i == loader_pkg::DL_ROM);
    assign tap_strb = beat_i.strb && (kind_i == loader_pkg::DL_TAP);

    // ====================
    // ROM regions
    // ====================
    always_comb begin
        rom_char = 1'b0;
        case (beat_i.ofs[15:13])
            // Drive ROM
            3'b000,
            3'b001: rom_addr = {9'h0, beat_i.ofs[13:0]};
            // PAL kernal
            3'b010: rom_addr = {7'h0, 3'b111, beat_i.ofs[12:0]};
            3'b011: begin
                rom_addr = {7'h0, 3'b111, beat_i.ofs[12:0]};
                rom_addr[`LDR_NTSC_BANK_BIT] = 1'b1;
            end
            // BASIC
            3'b100: rom_addr = {7'h0, 3'b110, beat_i.ofs[12:0]};
            3'b101: begin
                rom_addr = {7'h0, 4'b1000, beat_i.ofs[11:0]};
                rom_char = 1'b1;
            end
            default: rom_addr = '0;
        endcase
    end

    assign tap_addr = `LDR_TAP_BASE + beat_i.ofs[`LDR_ADDR_W-1:0];

    // Low RAM, the 4K block at $1000 and colour RAM sit inside the machine
    assign prg_internal = (prg_wr_i.addr[15:10] == 6'b000000) ||
                          (prg_wr_i.addr[15:12] == 4'b0001) ||
                          (prg_wr_i.addr[15:10] == 6'b100101);

    // ====================
    // Write request
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mem_req_o.we <= 1'b0;
            tap_end_o    <= `LDR_TAP_BASE;
        end else begin
            mem_req_o.we <= 1'b0;
            if (prg_wr_i.we) begin
                mem_req_o.we       <= 1'b1;
                mem_req_o.internal <= prg_wr_i.inject || prg_internal;
                mem_req_o.addr     <= {{(`LDR_ADDR_W-16){1'b0}}, prg_wr_i.addr};
                mem_req_o.data     <= prg_wr_i.data;
            end else if (rom_strb) begin
                mem_req_o.we       <= 1'b1;
                mem_req_o.internal <= rom_char;
                mem_req_o.addr     <= rom_addr;
                mem_req_o.data     <= beat_i.data;
            end else if (tap_strb) begin
                mem_req_o.we       <= 1'b1;
                mem_req_o.internal <= 1'b0;
                mem_req_o.addr     <= tap_addr;
                mem_req_o.data     <= beat_i.data;
            end
            // Tape end pointer for playback
            if (tap_strb) begin
                tap_end_o <= tap_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/loader_pkg.sv
design/load_settings.sv
design/download_decoder.sv
design/prg_loader.sv
design/target_addr_map.sv
design/loader_top.sv
tb/loader_checker.sv
tb/tb_loader.sv

// ==== tb/loader_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module loader_checker (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire                         dl_active_i,
    input  wire [`LDR_IDX_W-1:0]        dl_index_i,
    input  wire loader_pkg::dl_beat_t   beat_i,
    input  wire                         cfg_wr_i,
    input  wire [`LDR_CFG_W-1:0]        cfg_word_i,
    input  wire loader_pkg::mem_req_t   mem_req_i,
    input  wire [`LDR_ADDR_W-1:0]       tap_end_i,
    input  wire                         force_reset_i,
    input  wire                         finish_i,
    output logic                        done_o,
    output int                          err_total_o
);

    loader_pkg::mem_req_t exp_q[$];
    loader_pkg::dl_kind_t prev_kind;
    logic        no_hdr;
    logic [15:0] hdr;
    logic [15:0] last_ptr;
    logic        hit_cart;
    logic [`LDR_ADDR_W-1:0] tap_end_exp;
    int          reset_pending;
    int          value_errs = 0;
    int          missing_errs = 0;
    int          extra_errs = 0;
    int          reset_errs = 0;

    // ====================
    // Reference model
    // ====================
    function automatic loader_pkg::mem_req_t rom_expect(input logic [`LDR_OFS_W-1:0] ofs,
                                                        input logic [7:0] data);
        loader_pkg::mem_req_t r;
        r.we       = 1'b1;
        r.internal = 1'b0;
        r.data     = data;
        case (ofs[15:13])
            3'd0, 3'd1: r.addr = {9'd0, ofs[13:0]};
            3'd2:       r.addr = 23'h0E000 | {10'd0, ofs[12:0]};
            3'd3:       r.addr = 23'h1E000 | {10'd0, ofs[12:0]};
            3'd4:       r.addr = 23'h0C000 | {10'd0, ofs[12:0]};
            3'd5: begin
                // Character ROM
                r.addr     = 23'h08000 | {11'd0, ofs[11:0]};
                r.internal = 1'b1;
            end
            default:    r.addr = '0;
        endcase
        return r;
    endfunction

    function automatic logic [15:0] inj_target(input int n);
        case (n)
            0: return 16'h002D;
            1: return 16'h002E;
            2: return 16'h002F;
            3: return 16'h0030;
            4: return 16'h0031;
            5: return 16'h0032;
            6: return 16'h00AE;
            default: return 16'h00AF;
        endcase
    endfunction

    task automatic expect_prg(input logic [15:0] addr, input logic [7:0] data, input logic inj);
        loader_pkg::mem_req_t r;
        r.we       = 1'b1;
        r.addr     = {7'd0, addr};
        r.data     = data;
        r.internal = inj || (addr < 16'h0400) || (addr >= 16'h1000 && addr < 16'h2000) ||
                     (addr >= 16'h9400 && addr < 16'h9800);
        exp_q.push_back(r);
    endtask

    // Saturating PRG write at the given unclamped address
    task automatic prg_body(input int unsigned full, input logic [7:0] data);
        logic [15:0] addr;
        addr = (full > `LDR_PRG_LIMIT) ? `LDR_PRG_LIMIT : full[15:0];
        last_ptr = addr;
        if (addr == `LDR_PRG_NOHDR_ADDR) begin
            hit_cart = 1'b1;
        end
        expect_prg(addr, data, 1'b0);
    endtask

    task automatic update_model();
        loader_pkg::dl_kind_t kind;
        loader_pkg::mem_req_t r;
        kind = loader_pkg::DL_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                `LDR_IDX_ROM:                  kind = loader_pkg::DL_ROM;
                `LDR_IDX_PRG_A, `LDR_IDX_PRG_B: kind = loader_pkg::DL_PRG;
                `LDR_IDX_TAP:                  kind = loader_pkg::DL_TAP;
                default:                       kind = loader_pkg::DL_NONE;
            endcase
        end
        if (cfg_wr_i) begin
            no_hdr = cfg_word_i[`LDR_CFG_NO_HDR_BIT];
        end
        if (beat_i.strb && kind == loader_pkg::DL_ROM) begin
            exp_q.push_back(rom_expect(beat_i.ofs, beat_i.data));
        end else if (beat_i.strb && kind == loader_pkg::DL_TAP) begin
            r.we       = 1'b1;
            r.internal = 1'b0;
            r.addr     = `LDR_TAP_BASE + beat_i.ofs[`LDR_ADDR_W-1:0];
            r.data     = beat_i.data;
            exp_q.push_back(r);
            // Tape end moves one past the latest byte
            tap_end_exp = r.addr + 1'b1;
        end else if (beat_i.strb && kind == loader_pkg::DL_PRG) begin
            if (no_hdr) begin
                prg_body(`LDR_PRG_NOHDR_ADDR + beat_i.ofs, beat_i.data);
            end else if (beat_i.ofs == 0) begin
                hdr[7:0] = beat_i.data;
            end else if (beat_i.ofs == 1) begin
                hdr[15:8] = beat_i.data;
            end else begin
                prg_body(hdr + beat_i.ofs - 2, beat_i.data);
            end
        end
        // Eight pointer writes follow the end of a PRG with the low byte first
        if (prev_kind == loader_pkg::DL_PRG && kind != loader_pkg::DL_PRG) begin
            for (int n = 0; n < 8; n++) begin
                expect_prg(inj_target(n), n[0] ? last_ptr[15:8] : last_ptr[7:0], 1'b1);
            end
            if (hit_cart) begin
                reset_pending++;
            end
            hit_cart = 1'b0;
        end
        prev_kind = kind;
    endtask

    // ====================
    // Output comparison
    // ====================
    task automatic check_outputs();
        loader_pkg::mem_req_t e;
        if (mem_req_i.we && exp_q.size() == 0) begin
            $display("Extra write to address %h at %0t when no write was expected",
                     mem_req_i.addr, $time);
            extra_errs++;
        end else if (mem_req_i.we) begin
            e = exp_q.pop_front();
            if (mem_req_i.addr !== e.addr) begin
                $display("Fail at %0t: mem_req_o.addr expected %h got %h",
                         $time, e.addr, mem_req_i.addr);
                value_errs++;
            end
            if (mem_req_i.data !== e.data) begin
                $display("Fail at %0t: mem_req_o.data expected %h got %h",
                         $time, e.data, mem_req_i.data);
                value_errs++;
            end
            if (mem_req_i.internal !== e.internal) begin
                $display("Fail at %0t: mem_req_o.internal expected %b got %b",
                         $time, e.internal, mem_req_i.internal);
                value_errs++;
            end
        end
        if (tap_end_i !== tap_end_exp) begin
            $display("Fail at %0t: tap_end_o expected %h got %h",
                     $time, tap_end_exp, tap_end_i);
            value_errs++;
        end
        if (force_reset_i && reset_pending == 0) begin
            $display("Unexpected force_reset_o pulse at %0t", $time);
            reset_errs++;
        end else if (force_reset_i) begin
            reset_pending--;
        end
    endtask

    always @(posedge clk_sys) begin
        if (reset) begin
            exp_q.delete();
            prev_kind     = loader_pkg::DL_NONE;
            no_hdr        = 1'b0;
            hit_cart      = 1'b0;
            tap_end_exp   = `LDR_TAP_BASE;
            reset_pending = 0;
            done_o        <= 1'b0;
            err_total_o   <= 0;
        end else begin
            check_outputs();
            update_model();
            if (finish_i && !done_o) begin
                if (exp_q.size() != 0) begin
                    $display("%0d expected writes never appeared", exp_q.size());
                    missing_errs += exp_q.size();
                end
                if (reset_pending != 0) begin
                    $display("%0d expected force_reset_o pulses never appeared", reset_pending);
                    reset_errs += reset_pending;
                end
                $display("Errors: values %0d, missing %0d, extra %0d, resets %0d",
                         value_errs, missing_errs, extra_errs, reset_errs);
                err_total_o <= value_errs + missing_errs + extra_errs + reset_errs;
                done_o      <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module tb_loader;

    localparam int ROM_BEATS   = 24;
    localparam int HDR_BEATS   = 20;
    localparam int NOHDR_BEATS = 16;
    localparam int LOW_BEATS   = 12;
    localparam int LOW_LOADS   = 3;
    localparam int TAP_BEATS   = 16;
    localparam int DOWNLOADS   = 4 + LOW_LOADS;
    localparam int ALL_BEATS   = ROM_BEATS + HDR_BEATS + NOHDR_BEATS +
                                 LOW_BEATS * LOW_LOADS + TAP_BEATS;
    // Six cycles per beat at most and forty idle cycles per download
    localparam int CYCLE_LIMIT = ALL_BEATS * 6 + DOWNLOADS * 40 + 200;

    logic                   clk_sys;
    logic                   reset;
    logic                   dl_active;
    logic [`LDR_IDX_W-1:0]  dl_index;
    loader_pkg::dl_beat_t   beat;
    logic                   cfg_wr;
    logic [`LDR_CFG_W-1:0]  cfg_word;
    loader_pkg::mem_req_t   mem_req;
    logic [`LDR_ADDR_W-1:0] tap_end;
    logic                   force_reset;
    logic                   finish_chk;
    logic                   chk_done;
    int                     err_total;
    int                     cycles = 0;
    int unsigned            seed;
    int unsigned            rnd;
    logic [15:0]            hdr;
    logic [`LDR_OFS_W-1:0]  ofs;

    loader_top UUT (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_active_i   (dl_active),
        .dl_index_i    (dl_index),
        .beat_i        (beat),
        .cfg_wr_i      (cfg_wr),
        .cfg_word_i    (cfg_word),
        .mem_req_o     (mem_req),
        .tap_end_o     (tap_end),
        .force_reset_o (force_reset)
    );

    loader_checker u_check (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_active_i   (dl_active),
        .dl_index_i    (dl_index),
        .beat_i        (beat),
        .cfg_wr_i      (cfg_wr),
        .cfg_word_i    (cfg_word),
        .mem_req_i     (mem_req),
        .tap_end_i     (tap_end),
        .force_reset_i (force_reset),
        .finish_i      (finish_chk),
        .done_o        (chk_done),
        .err_total_o   (err_total)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Address where an internal range starts or stops
    function automatic logic [15:0] range_edge(input int n);
        case (n)
            0: return 16'h0400;
            1: return 16'h1000;
            default: return 16'h9400;
        endcase
    endfunction

    // ====================
    // Stimulus tasks
    // ====================
    // Strobe then 2 to 5 idle cycles
    task automatic send_beat(input logic [`LDR_OFS_W-1:0] o, input logic [7:0] data);
        int unsigned gap;
        gap = 1 + ($urandom % 4);
        @(posedge clk_sys);
        beat.strb <= 1'b1;
        beat.ofs  <= o;
        beat.data <= data;
        @(posedge clk_sys);
        beat.strb <= 1'b0;
        repeat (gap) @(posedge clk_sys);
    endtask

    task automatic open_download(input logic [`LDR_IDX_W-1:0] idx);
        @(posedge clk_sys);
        dl_active <= 1'b1;
        dl_index  <= idx;
    endtask

    // Leaves room for the pointer injection to finish
    task automatic close_download();
        @(posedge clk_sys);
        dl_active <= 1'b0;
        repeat (40) @(posedge clk_sys);
    endtask

    task automatic write_config(input logic [`LDR_CFG_W-1:0] word);
        @(posedge clk_sys);
        cfg_wr   <= 1'b1;
        cfg_word <= word;
        @(posedge clk_sys);
        cfg_wr   <= 1'b0;
    endtask

    task automatic load_prg(input logic [7:0] idx, input logic with_hdr,
                            input logic [15:0] load_addr, input int count);
        logic [7:0] data;
        open_download(idx);
        for (int k = 0; k < count; k++) begin
            data = $urandom;
            if (with_hdr && k == 0) begin
                data = load_addr[7:0];
            end else if (with_hdr && k == 1) begin
                data = load_addr[15:8];
            end
            send_beat(k, data);
        end
        close_download();
    endtask

    initial begin
        seed       = 46;
        rnd        = $urandom(seed);
        reset      = 1'b1;
        dl_active  = 1'b0;
        dl_index   = '0;
        beat       = '0;
        cfg_wr     = 1'b0;
        cfg_word   = '0;
        finish_chk = 1'b0;
        repeat (4) @(posedge clk_sys);
        reset <= 1'b0;

        // ROM bytes spread over every region code
        open_download(`LDR_IDX_ROM);
        for (int i = 0; i < ROM_BEATS; i++) begin
            ofs = (i % 8) * 32'h2000 + ($urandom % 32'h2000);
            send_beat(ofs, $urandom);
        end
        close_download();

        // Header close to the limit so the pointer saturates
        hdr = 16'hBFF8 - ($urandom % 8);
        load_prg(`LDR_IDX_PRG_A, 1'b1, hdr, HDR_BEATS);

        write_config($urandom | (32'd1 << `LDR_CFG_NO_HDR_BIT));
        load_prg(`LDR_IDX_PRG_B, 1'b0, 16'h0000, NOHDR_BEATS);

        write_config($urandom & ~(32'd1 << `LDR_CFG_NO_HDR_BIT));
        // Each load crosses the edge of one internal range
        for (int i = 0; i < LOW_LOADS; i++) begin
            hdr = range_edge(i) - 16'd5 + ($urandom % 4);
            load_prg(`LDR_IDX_PRG_A, 1'b1, hdr, LOW_BEATS);
        end

        open_download(`LDR_IDX_TAP);
        for (int i = 0; i < TAP_BEATS; i++) begin
            send_beat(i, $urandom);
        end
        close_download();

        @(posedge clk_sys);
        finish_chk <= 1'b1;
        while (!chk_done) @(posedge clk_sys);
        if (err_total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
